/* common/memsys_defines.svh */
// Data word width, data memory depth and word index width macros
`ifndef MEMSYS_DEFINES_SVH
`define MEMSYS_DEFINES_SVH

// Width of a data word and of the data bus
`define XLEN 32

// Number of words in the data memory
`define DMEM_DEPTH 256

// Word index width, log2 of the memory depth
`define DMEM_AW 8

// Byte lanes in one data word
`define XLEN_BYTES (`XLEN / 8)

`endif

/* common/memsys_pkg.sv */
// Package with the load, store and AMO operation enums and the AMO FSM state enum
package memsys_pkg;

    // Load operations from the execute stage
    typedef enum logic [2:0] {
        LD_OPS_NONE = 3'd0,
        LD_OPS_LB   = 3'd1,
        LD_OPS_LBU  = 3'd2,
        LD_OPS_LH   = 3'd3,
        LD_OPS_LHU  = 3'd4,
        LD_OPS_LW   = 3'd5
    } type_ld_ops_e;

    // Store operations, size only
    typedef enum logic [1:0] {
        ST_OPS_NONE = 2'd0,
        ST_OPS_SB   = 2'd1,
        ST_OPS_SH   = 2'd2,
        ST_OPS_SW   = 2'd3
    } type_st_ops_e;

    // Atomic memory operations
    typedef enum logic [3:0] {
        AMO_OPS_NONE = 4'd0,
        AMO_OPS_SWAP = 4'd1,
        AMO_OPS_ADD  = 4'd2,
        AMO_OPS_AND  = 4'd3,
        AMO_OPS_OR   = 4'd4,
        AMO_OPS_XOR  = 4'd5,
        // Min/max forms, signed first then unsigned
        AMO_OPS_MIN  = 4'd6,
        AMO_OPS_MAX  = 4'd7,
        AMO_OPS_MINU = 4'd8,
        AMO_OPS_MAXU = 4'd9
    } type_amo_ops_e;

    // Read-modify-write sequence of the AMO unit
    typedef enum logic [1:0] {
        AMO_IDLE  = 2'd0,
        AMO_READ  = 2'd1,
        AMO_WRITE = 2'd2,
        AMO_DONE  = 2'd3
    } type_amo_state_e;

endpackage : memsys_pkg

/* common/dbus_if.sv */
// Data bus interface with master and slave modports
`include "memsys_defines.svh"

interface dbus_if ();

    // Byte address, low two bits select the lane
    logic [`XLEN-1:0]       addr;
    // Store data already placed on its lanes
    logic [`XLEN-1:0]       w_data;
    logic [`XLEN_BYTES-1:0] byte_en;
    // Request levels, held until ack
    logic                   ld_req;
    logic                   st_req;
    // Slave response, ack is a single-cycle pulse
    logic [`XLEN-1:0]       r_data;
    logic                   ack;

    // Requesting side
    modport master (
        output addr, w_data, byte_en, ld_req, st_req,
        input  r_data, ack
    );

    // Responding side
    modport slave (
        input  addr, w_data, byte_en, ld_req, st_req,
        output r_data, ack
    );

endinterface : dbus_if

/* common/amo_if.sv */
// Interface between the load/store unit and the AMO unit with modports
`include "memsys_defines.svh"

interface amo_if import memsys_pkg::*; ();

    // Start level, held with its fields until done
    logic             start;
    type_amo_ops_e    amo_ops;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] rs2_data;
    // One-cycle completion pulse, result is the old memory word
    logic             done;
    logic [`XLEN-1:0] result;

    // Load/store unit side
    modport lsu (
        output start, amo_ops, addr, rs2_data,
        input  done, result
    );

    // AMO unit side
    modport amo (
        input  start, amo_ops, addr, rs2_data,
        output done, result
    );

endinterface : amo_if

/* lsu/lsu.sv */
// Load/store unit with decode, store lane steering, byte enables, load extension and result select
`include "memsys_defines.svh"

module lsu
    import memsys_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n_i,
    input  type_ld_ops_e     ld_ops_i,
    input  type_st_ops_e     st_ops_i,
    input  type_amo_ops_e    amo_ops_i,
    input  logic [`XLEN-1:0] addr_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    output logic             lsu_ack_o,
    output logic [`XLEN-1:0] wrb_data_o,
    dbus_if.master           dbus,
    amo_if.lsu               amo
);

    logic             is_amo;
    type_ld_ops_e     ld_ops_q;
    logic [1:0]       lane_q;
    logic [7:0]       rdata_byte;
    logic [15:0]      rdata_hword;
    logic [`XLEN-1:0] ld_data;

    // Any AMO opcode routes the instruction to the AMO unit
    assign is_amo = (amo_ops_i != AMO_OPS_NONE);

    // Plain loads and stores go straight onto the bus
    assign dbus.ld_req = (ld_ops_i != LD_OPS_NONE) & ~is_amo;
    assign dbus.st_req = (st_ops_i != ST_OPS_NONE) & ~is_amo;
    assign dbus.addr   = addr_i;

    // Byte enables from access size and low address bits
    always_comb begin
        case (st_ops_i)
            ST_OPS_SB: dbus.byte_en = 4'b0001 << addr_i[1:0];
            ST_OPS_SH: dbus.byte_en = addr_i[1] ? 4'b1100 : 4'b0011;
            ST_OPS_SW: dbus.byte_en = 4'b1111;
            default:   dbus.byte_en = 4'b0000;
        endcase
    end

    // Replicate store data so every enabled lane sees it
    always_comb begin
        case (st_ops_i)
            ST_OPS_SB: dbus.w_data = {4{rs2_data_i[7:0]}};
            ST_OPS_SH: dbus.w_data = {2{rs2_data_i[15:0]}};
            default:   dbus.w_data = rs2_data_i;
        endcase
    end

    // AMO request fields, held by the execute side until done
    assign amo.start    = is_amo;
    assign amo.amo_ops  = amo_ops_i;
    assign amo.addr     = addr_i;
    assign amo.rs2_data = rs2_data_i;

    // Access kind and lane travel with the registered memory read
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ld_ops_q <= LD_OPS_NONE;
        end else begin
            ld_ops_q <= is_amo ? LD_OPS_NONE : ld_ops_i;
        end
        lane_q <= addr_i[1:0];
    end

    // Pick the byte and halfword lanes out of the read word
    always_comb begin
        case (lane_q)
            2'b00:   rdata_byte = dbus.r_data[7:0];
            2'b01:   rdata_byte = dbus.r_data[15:8];
            2'b10:   rdata_byte = dbus.r_data[23:16];
            default: rdata_byte = dbus.r_data[31:24];
        endcase
        rdata_hword = lane_q[1] ? dbus.r_data[31:16] : dbus.r_data[15:0];
    end

    // Sign or zero extension, stores fall to zero
    always_comb begin
        case (ld_ops_q)
            LD_OPS_LB:  ld_data = {{24{rdata_byte[7]}}, rdata_byte};
            LD_OPS_LBU: ld_data = {24'b0, rdata_byte};
            LD_OPS_LH:  ld_data = {{16{rdata_hword[15]}}, rdata_hword};
            LD_OPS_LHU: ld_data = {16'b0, rdata_hword};
            LD_OPS_LW:  ld_data = dbus.r_data;
            default:    ld_data = '0;
        endcase
    end

    // AMO result wins while done pulses
    assign wrb_data_o = amo.done ? amo.result : (dbus.ack ? ld_data : '0);

    // Completion from the unit that owns the instruction
    assign lsu_ack_o = is_amo ? amo.done : dbus.ack;

endmodule : lsu

/* lsu/amo_unit.sv */
// AMO unit with a read-modify-write FSM and the AMO arithmetic
`include "memsys_defines.svh"

module amo_unit
    import memsys_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    amo_if.amo     amo,
    dbus_if.master dbus
);

    type_amo_state_e  state_q;
    type_amo_state_e  state_d;
    logic [`XLEN-1:0] old_q;
    logic [`XLEN-1:0] new_val;

    // New word from the old memory value and rs2
    always_comb begin
        case (amo.amo_ops)
            AMO_OPS_SWAP: new_val = amo.rs2_data;
            AMO_OPS_ADD:  new_val = old_q + amo.rs2_data;
            AMO_OPS_AND:  new_val = old_q & amo.rs2_data;
            AMO_OPS_OR:   new_val = old_q | amo.rs2_data;
            AMO_OPS_XOR:  new_val = old_q ^ amo.rs2_data;
            // Signed compare for min/max
            AMO_OPS_MIN:  new_val = ($signed(old_q) < $signed(amo.rs2_data)) ? old_q : amo.rs2_data;
            AMO_OPS_MAX:  new_val = ($signed(old_q) > $signed(amo.rs2_data)) ? old_q : amo.rs2_data;
            AMO_OPS_MINU: new_val = (old_q < amo.rs2_data) ? old_q : amo.rs2_data;
            AMO_OPS_MAXU: new_val = (old_q > amo.rs2_data) ? old_q : amo.rs2_data;
            default:      new_val = old_q;
        endcase
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            AMO_IDLE:  if (amo.start) state_d = AMO_READ;
            AMO_READ:  if (dbus.ack) state_d = AMO_WRITE;
            AMO_WRITE: if (dbus.ack) state_d = AMO_DONE;
            default:   state_d = AMO_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= AMO_IDLE;
        end else begin
            state_q <= state_d;
        end
        // Old word captured on the read ack
        if (state_q == AMO_READ && dbus.ack) begin
            old_q <= dbus.r_data;
        end
    end

    // Read launches in the start cycle and stays up through READ
    assign dbus.ld_req  = (state_q == AMO_READ) | ((state_q == AMO_IDLE) & amo.start);
    assign dbus.st_req  = (state_q == AMO_WRITE);
    assign dbus.addr    = amo.addr;
    assign dbus.w_data  = new_val;
    assign dbus.byte_en = 4'b1111;

    // Old value goes back as the write-back result
    assign amo.done   = (state_q == AMO_DONE);
    assign amo.result = old_q;

endmodule : amo_unit

/* rtl/dbus_arbiter.sv */
// Two-master data bus arbiter with AMO priority and AMO lock
module dbus_arbiter (
    input  logic   clk,
    input  logic   rst_n_i,
    dbus_if.slave  lsu_bus,
    dbus_if.slave  amo_bus,
    dbus_if.master mem_bus
);

    logic amo_req;
    logic lock_q;
    logic grant_amo;

    assign amo_req = amo_bus.ld_req | amo_bus.st_req;

    // AMO unit owns the bus while it requests or holds the lock
    assign grant_amo = amo_req | lock_q;

    // Lock spans the read and write, released on the write ack
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lock_q <= 1'b0;
        end else if (lock_q && amo_bus.st_req && mem_bus.ack) begin
            lock_q <= 1'b0;
        end else if (amo_req) begin
            lock_q <= 1'b1;
        end
    end

    // Request fields from the granted master
    assign mem_bus.addr    = grant_amo ? amo_bus.addr    : lsu_bus.addr;
    assign mem_bus.w_data  = grant_amo ? amo_bus.w_data  : lsu_bus.w_data;
    assign mem_bus.byte_en = grant_amo ? amo_bus.byte_en : lsu_bus.byte_en;
    assign mem_bus.ld_req  = grant_amo ? amo_bus.ld_req  : lsu_bus.ld_req;
    assign mem_bus.st_req  = grant_amo ? amo_bus.st_req  : lsu_bus.st_req;

    // Read data is shared, ack only to the owner
    assign lsu_bus.r_data = mem_bus.r_data;
    assign amo_bus.r_data = mem_bus.r_data;
    assign lsu_bus.ack    = mem_bus.ack & ~grant_amo;
    assign amo_bus.ack    = mem_bus.ack & grant_amo;

endmodule : dbus_arbiter

/* rtl/data_mem.sv */
// Byte-enabled word data memory with a registered one-cycle ack
`include "memsys_defines.svh"

module data_mem (
    input  logic  clk,
    input  logic  rst_n_i,
    dbus_if.slave bus
);

    logic [`XLEN-1:0]    mem [`DMEM_DEPTH];
    logic [`DMEM_AW-1:0] word_idx;
    logic                access;
    logic                ack_q;
    logic [`XLEN-1:0]    r_data_q;

    // Word part of the byte address
    assign word_idx = bus.addr[`DMEM_AW+1:2];

    // No new access in the ack cycle, leaves a gap between accesses
    assign access = (bus.ld_req | bus.st_req) & ~ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ack_q <= access;
            if (access) begin
                // Old word read, write lands at the same edge
                r_data_q <= mem[word_idx];
                if (bus.st_req) begin
                    for (int b = 0; b < `XLEN_BYTES; b++) begin
                        if (bus.byte_en[b]) mem[word_idx][8*b +: 8] <= bus.w_data[8*b +: 8];
                    end
                end
            end
        end
    end

    assign bus.r_data = r_data_q;
    assign bus.ack    = ack_q;

endmodule : data_mem

/* rtl/memsys_top.sv */
// Memory subsystem top level with the LSU, AMO unit, bus arbiter and data memory
`include "memsys_defines.svh"

module memsys_top
    import memsys_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n_i,
    // Execute side, one operation held until lsu_ack_o
    input  type_ld_ops_e     ld_ops_i,
    input  type_st_ops_e     st_ops_i,
    input  type_amo_ops_e    amo_ops_i,
    input  logic [`XLEN-1:0] addr_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    // Completion and write-back value
    output logic             lsu_ack_o,
    output logic [`XLEN-1:0] wrb_data_o
);

    // LSU and AMO masters, and the memory side of the arbiter
    dbus_if lsu_bus ();
    dbus_if amo_bus ();
    dbus_if mem_bus ();

    // LSU hands AMOs over here
    amo_if  amo_link ();

    lsu lsu_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ld_ops_i   (ld_ops_i),
        .st_ops_i   (st_ops_i),
        .amo_ops_i  (amo_ops_i),
        .addr_i     (addr_i),
        .rs2_data_i (rs2_data_i),
        .lsu_ack_o  (lsu_ack_o),
        .wrb_data_o (wrb_data_o),
        .dbus       (lsu_bus),
        .amo        (amo_link)
    );

    amo_unit amo_unit_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .amo     (amo_link),
        .dbus    (amo_bus)
    );

    // AMO master gets priority and the lock
    dbus_arbiter dbus_arbiter_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .lsu_bus (lsu_bus),
        .amo_bus (amo_bus),
        .mem_bus (mem_bus)
    );

    data_mem data_mem_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (mem_bus)
    );

endmodule : memsys_top

/* test/tb_clock.sv */
// Free-running clock generator for the testbench
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    // Starts low, toggles every half period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule : tb_clock

/* test/tb_memsys.sv */
// Testbench for the memory subsystem, reads the case file and checks write-back and ack timing
`include "memsys_defines.svh"

module tb_memsys
    import memsys_pkg::*;
();

    // Inputs change and outputs are sampled this long after the rising edge
    localparam int DRIVE_DLY   = 10;
    localparam int ACK_TIMEOUT = 20;

    logic             clk;
    logic             rst_n;
    type_ld_ops_e     ld_ops;
    type_st_ops_e     st_ops;
    type_amo_ops_e    amo_ops;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] rs2_data;
    logic             lsu_ack;
    logic [`XLEN-1:0] wrb_data;

    tb_clock #(.PERIOD(100)) tb_clock_i (.clk_o(clk));

    memsys_top memsys_top_i (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .ld_ops_i   (ld_ops),
        .st_ops_i   (st_ops),
        .amo_ops_i  (amo_ops),
        .addr_i     (addr),
        .rs2_data_i (rs2_data),
        .lsu_ack_o  (lsu_ack),
        .wrb_data_o (wrb_data)
    );

    // Compare one value with its expectation
    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // Any failure that is not a wrong value
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // All ops back to NONE for an idle execute side
    task automatic clear_ops();
        ld_ops  = LD_OPS_NONE;
        st_ops  = ST_OPS_NONE;
        amo_ops = AMO_OPS_NONE;
    endtask

    // Put one operation on the DUT inputs
    // The code is the enum value within its kind
    task automatic drive_op(input string kind, input logic [3:0] code,
                            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] d);
        clear_ops();
        addr     = a;
        rs2_data = d;
        case (kind)
            "LD":    ld_ops  = type_ld_ops_e'(code[2:0]);
            "ST":    st_ops  = type_st_ops_e'(code[1:0]);
            "AMO":   amo_ops = type_amo_ops_e'(code);
            default: abort_run({"Unknown operation kind ", kind, " in the case file"});
        endcase
    endtask

    initial begin
        int               fd;
        int               fields;
        int               n_cases;
        int               cycles;
        int               exp_cycles;
        logic             acked;
        string            line;
        string            name;
        string            kind;
        logic [3:0]       code;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] d;
        logic [`XLEN-1:0] expected;

        n_cases  = 0;
        rst_n    = 1'b0;
        addr     = '0;
        rs2_data = '0;
        clear_ops();

        // Synchronous reset over two rising edges
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        fd = $fopen("test/memsys_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the case file test/memsys_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%s %s %h %h %h %h", name, kind, code, a, d, expected);
            // Skip the column comments and blank lines
            if (line.len() > 0 && line.getc(0) != "#" && fields == 6) begin
                n_cases++;
                // Loads and stores ack after one edge and AMOs after four
                exp_cycles = (kind == "AMO") ? 4 : 1;
                drive_op(kind, code, a, d);
                cycles = 0;
                acked  = 1'b0;
                while (!acked && cycles < ACK_TIMEOUT) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                    cycles++;
                    acked = lsu_ack;
                end
                if (!acked) begin
                    abort_run({"Operation ", kind, " of case ", name, " never acknowledged"});
                end else begin
                    check_value(name, expected, wrb_data);
                    check_value({name, "_cycles"}, exp_cycles, cycles);
                end
                // Request dropped for one cycle before the next case
                clear_ops();
                @(posedge clk);
                #DRIVE_DLY;
            end
        end
        $fclose(fd);

        if (n_cases == 0) begin
            abort_run("The case file holds no cases");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule : tb_memsys

/* test/memsys_cases.txt */
# name kind code addr data expected_wrb, all numbers hex, memory is zero after reset
# code: LD LB=1 LBU=2 LH=3 LHU=4 LW=5, ST SB=1 SH=2 SW=3, AMO SWAP=1 ADD..XOR=2..5 MIN..MAXU=6..9
lw_reset     LD  5 00000040 00000000 00000000
sw_word      ST  3 00000010 12345678 00000000
lw_word      LD  5 00000010 00000000 12345678
sw_base      ST  3 00000020 11223344 00000000
sb_lane3     ST  1 00000023 000000ab 00000000
sh_lane0     ST  2 00000020 00005566 00000000
lw_merge     LD  5 00000020 00000000 ab225566
sw_signs     ST  3 00000030 80f17f9c 00000000
lb_neg       LD  1 00000030 00000000 ffffff9c
lbu_neg      LD  2 00000030 00000000 0000009c
lh_neg       LD  3 00000032 00000000 ffff80f1
lhu_neg      LD  4 00000032 00000000 000080f1
lh_pos       LD  3 00000030 00000000 00007f9c
sw_amo_init  ST  3 00000040 00000005 00000000
amo_swap     AMO 1 00000040 0000000a 00000005
amo_add      AMO 2 00000040 00000003 0000000a
amo_and      AMO 3 00000040 00000006 0000000d
amo_or       AMO 4 00000040 00000030 00000004
amo_xor      AMO 5 00000040 000000ff 00000034
amo_min      AMO 6 00000040 fffffff0 000000cb
amo_max      AMO 7 00000040 00000007 fffffff0
amo_minu     AMO 8 00000040 80000000 00000007
amo_maxu     AMO 9 00000040 80000000 00000007
lw_amo_final LD  5 00000040 00000000 80000000
mix_sw       ST  3 00000050 00000100 00000000
mix_amo_add  AMO 2 00000050 00000023 00000100
mix_lw       LD  5 00000050 00000000 00000123

/* memsys.f */
+incdir+common
common/memsys_pkg.sv
common/dbus_if.sv
common/amo_if.sv
lsu/lsu.sv
lsu/amo_unit.sv
rtl/dbus_arbiter.sv
rtl/data_mem.sv
rtl/memsys_top.sv
test/tb_clock.sv
test/tb_memsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_memsys
FLIST     ?= memsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
